//--- hw/cache_pkg.sv
package cache_pkg;

	localparam int LINE_WORDS = 4;
	localparam int NUM_LINES = 256;

	typedef logic [15:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [4:0] tag_t;
	typedef logic [7:0] index_t;
	typedef logic [2:0] offset_t;

	// Write-back and fill states must stay consecutive
	typedef enum logic [3:0] {
		idle,
		cmp_rd,
		cmp_wr,
		hit_done,
		wb_0, wb_1, wb_2, wb_3,
		fill_0, fill_1, fill_2, fill_3, fill_4, fill_5,
		recmp_rd,
		recmp_wr
	} ctrl_state_t;

endpackage

//--- hw/cache_array_if.sv
`timescale 1ns/1ps

interface cache_array_if;
	import cache_pkg::*;

	// Controller side
	logic enable;
	logic cmp;
	logic wr;
	logic valid_in;
	index_t index;
	offset_t offset;
	tag_t tag;
	word_t data_in;

	// Store side
	logic hit;
	logic valid;
	logic dirty;
	tag_t tag_out;
	word_t data_out;

	modport ctrl (
		output enable, cmp, wr, valid_in, index, offset, tag, data_in,
		input hit, valid, dirty, tag_out, data_out
	);

	modport store (
		input enable, cmp, wr, valid_in, index, offset, tag, data_in,
		output hit, valid, dirty, tag_out, data_out
	);

endinterface

//--- hw/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
	input logic clk,
	input logic rst,
	cache_array_if.store arr
);
	import cache_pkg::*;

	tag_t tags [NUM_LINES];
	logic dirty_bits [NUM_LINES];
	logic [NUM_LINES-1:0] valid_bits;
	logic line_wr;

	assign line_wr = arr.enable && arr.wr;

	assign arr.tag_out = tags[arr.index];
	assign arr.valid = valid_bits[arr.index];
	assign arr.dirty = dirty_bits[arr.index];
	assign arr.hit = (tags[arr.index] == arr.tag);

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_bits <= '0;
		else if (line_wr && !arr.cmp)
			valid_bits[arr.index] <= arr.valid_in;
	end

	// Compare write dirties the line, fill write installs a clean tag
	always_ff @(posedge clk)
	begin
		if (line_wr)
		begin
			if (arr.cmp)
				dirty_bits[arr.index] <= 1'b1;
			else
			begin
				tags[arr.index] <= arr.tag;
				dirty_bits[arr.index] <= 1'b0;
			end
		end
	end

endmodule

//--- hw/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
	input logic clk,
	cache_array_if.store arr
);
	import cache_pkg::*;

	word_t lines [NUM_LINES][LINE_WORDS];
	logic [1:0] word_sel;

	// Words at even byte offsets
	assign word_sel = arr.offset[2:1];
	assign arr.data_out = lines[arr.index][word_sel];

	always_ff @(posedge clk)
	begin
		if (arr.wr)
			lines[arr.index][word_sel] <= arr.data_in;
	end

endmodule

//--- hw/bank_memory.sv
`timescale 1ns/1ps

module bank_memory #(
	parameter int MEM_LATENCY = 2
) (
	input logic clk,
	input logic rd,
	input logic wr,
	input cache_pkg::addr_t addr,
	input cache_pkg::word_t wdata,
	output cache_pkg::word_t rdata
);
	import cache_pkg::*;

	localparam int BANK_WORDS = 8192;

	word_t banks [4][BANK_WORDS];
	word_t rd_pipe [MEM_LATENCY];
	logic [1:0] bank_sel;
	logic [12:0] row;

	// Consecutive words go to consecutive banks
	assign bank_sel = addr[2:1];
	assign row = addr[15:3];

	assign rdata = rd_pipe[MEM_LATENCY-1];

	always_ff @(posedge clk)
	begin
		if (wr)
			banks[bank_sel][row] <= wdata;
	end

	// One stage per cycle of latency, a new read may enter each cycle
	always_ff @(posedge clk)
	begin
		if (rd)
			rd_pipe[0] <= banks[bank_sel][row];
		for (int i = 1; i < MEM_LATENCY; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int MEM_LATENCY = 2
) (
	input logic clk,
	input logic rst,
	input cache_pkg::addr_t addr,
	input cache_pkg::word_t data_in,
	input logic rd,
	input logic wr,
	output logic done,
	output logic cache_hit,
	output logic stall,
	cache_array_if.ctrl arr,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	output logic mem_wr,
	output logic mem_rd,
	input cache_pkg::word_t mem_rdata
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	tag_t req_tag;
	index_t req_index;
	logic [3:0] wb_step;
	logic [3:0] fill_step;
	logic [3:0] fill_wr_step;
	logic line_hit;
	logic victim_dirty;

	assign req_tag = addr[15:11];
	assign req_index = addr[10:3];

	// Word position within the write-back and fill sequences
	assign wb_step = 4'(state) - 4'(wb_0);
	assign fill_step = 4'(state) - 4'(fill_0);
	assign fill_wr_step = fill_step - 4'(MEM_LATENCY);

	assign line_hit = arr.hit && arr.valid;
	assign victim_dirty = arr.valid && arr.dirty;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		arr.enable = 1'b0;
		arr.cmp = 1'b0;
		arr.wr = 1'b0;
		arr.valid_in = 1'b0;
		arr.index = req_index;
		arr.offset = addr[2:0];
		arr.tag = req_tag;
		arr.data_in = data_in;
		mem_addr = addr;
		mem_wdata = arr.data_out;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		done = 1'b0;
		cache_hit = 1'b0;
		stall = 1'b1;

		case (state)
			idle:
			begin
				stall = 1'b0;
				if (rd)
					next_state = cmp_rd;
				else if (wr)
					next_state = cmp_wr;
			end
			cmp_rd, cmp_wr:
			begin
				arr.enable = 1'b1;
				arr.cmp = 1'b1;
				arr.wr = (state == cmp_wr) && line_hit;
				if (line_hit)
					next_state = hit_done;
				else if (victim_dirty)
					next_state = wb_0;
				else
					next_state = fill_0;
			end
			hit_done:
			begin
				arr.enable = 1'b1;
				arr.cmp = 1'b1;
				done = 1'b1;
				cache_hit = 1'b1;
				next_state = idle;
			end
			wb_0, wb_1, wb_2, wb_3:
			begin
				// Stream victim line out at its own address
				arr.enable = 1'b1;
				arr.offset = {wb_step[1:0], 1'b0};
				mem_addr = {arr.tag_out, req_index, wb_step[1:0], 1'b0};
				mem_wr = 1'b1;
				if (state == wb_3)
					next_state = fill_0;
				else
					next_state = ctrl_state_t'(state + 4'd1);
			end
			fill_0, fill_1, fill_2, fill_3, fill_4, fill_5:
			begin
				arr.enable = 1'b1;
				if (fill_step < 4'(LINE_WORDS))
				begin
					mem_rd = 1'b1;
					mem_addr = {addr[15:3], fill_step[1:0], 1'b0};
				end
				// Returning word lands MEM_LATENCY states after its read
				if (fill_step >= 4'(MEM_LATENCY) && fill_wr_step < 4'(LINE_WORDS))
				begin
					arr.wr = 1'b1;
					arr.valid_in = 1'b1;
					arr.offset = {fill_wr_step[1:0], 1'b0};
					arr.data_in = mem_rdata;
				end
				if (state == fill_5)
					next_state = wr ? recmp_wr : recmp_rd;
				else
					next_state = ctrl_state_t'(state + 4'd1);
			end
			recmp_rd, recmp_wr:
			begin
				arr.enable = 1'b1;
				arr.cmp = 1'b1;
				arr.wr = (state == recmp_wr) && line_hit;
				done = 1'b1;
				next_state = idle;
			end
		endcase
	end

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
	parameter int MEM_LATENCY = 2
) (
	input logic clk,
	input logic rst,
	input cache_pkg::addr_t addr,
	input cache_pkg::word_t data_in,
	input logic rd,
	input logic wr,
	output cache_pkg::word_t data_out,
	output logic done,
	output logic cache_hit,
	output logic stall
);
	import cache_pkg::*;

	addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_wr;
	logic mem_rd;

	cache_array_if arr_if ();

	cache_ctrl #(
		.MEM_LATENCY(MEM_LATENCY)
	) ctrl_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.done(done),
		.cache_hit(cache_hit),
		.stall(stall),
		.arr(arr_if),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wr(mem_wr),
		.mem_rd(mem_rd),
		.mem_rdata(mem_rdata)
	);

	cache_tag_store tag_i (
		.clk(clk),
		.rst(rst),
		.arr(arr_if)
	);

	cache_data_store data_i (
		.clk(clk),
		.arr(arr_if)
	);

	bank_memory #(
		.MEM_LATENCY(MEM_LATENCY)
	) mem_i (
		.clk(clk),
		.rd(mem_rd),
		.wr(mem_wr),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	assign data_out = arr_if.data_out;

endmodule

//--- sim/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
	import cache_pkg::*;

	localparam int MEM_LATENCY = 2;
	localparam int HIT_CYCLES = 2;
	localparam int CLEAN_MISS_CYCLES = 8;
	localparam int DIRTY_MISS_CYCLES = 12;
	localparam int TIMEOUT_CYCLES = 40;
	localparam int MAX_ROWS = 128;
	localparam int NUM_RANDOM = 32;

	// Fixed rows use their own indices
	localparam tag_t TAG_A = 5'h0a;
	localparam tag_t TAG_B = 5'h15;
	localparam index_t IDX_F = 8'h05;
	localparam index_t IDX_G = 8'h40;

	logic clk;
	logic rst;
	addr_t addr;
	word_t data_in;
	logic rd;
	logic wr;
	word_t data_out;
	logic done;
	logic cache_hit;
	logic stall;

	// Operation table
	logic row_wr [MAX_ROWS];
	addr_t row_addr [MAX_ROWS];
	word_t row_wdata [MAX_ROWS];
	logic row_hit [MAX_ROWS];
	word_t row_data [MAX_ROWS];
	int row_lat [MAX_ROWS];
	int n_rows;
	int n_fixed;

	// Random address pool
	tag_t rand_tags [3];
	index_t rand_idx [4];

	// Reference model
	word_t model_mem [addr_t];
	tag_t res_tag [NUM_LINES];
	logic res_valid [NUM_LINES];
	logic res_dirty [NUM_LINES];

	// Words written so far for choosing reads
	bit written [addr_t];
	addr_t written_q [$];

	int errors;
	int checks;
	int cur_test;
	logic timed_out;

	cache_top #(
		.MEM_LATENCY(MEM_LATENCY)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.cache_hit(cache_hit),
		.stall(stall)
	);

	initial
		clk = 1'b0;

	always #4 clk = ~clk;

	function automatic addr_t make_addr(input tag_t tg, input index_t idx, input logic [1:0] word);
		return {tg, idx, word, 1'b0};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] test %0d %s: got %h, expected %h", cur_test, name, got, exp);
		end
	endtask

	task automatic add_row(input logic is_wr, input addr_t a, input word_t wdata,
		input logic exp_hit, input word_t exp_data, input int exp_lat);
		row_wr[n_rows] = is_wr;
		row_addr[n_rows] = a;
		row_wdata[n_rows] = wdata;
		row_hit[n_rows] = exp_hit;
		row_data[n_rows] = exp_data;
		row_lat[n_rows] = exp_lat;
		if (is_wr && !written.exists(a))
		begin
			written[a] = 1'b1;
			written_q.push_back(a);
		end
		n_rows++;
	endtask

	task automatic build_fixed_rows();
		// Cold write miss and then a read hit
		add_row(1'b1, make_addr(TAG_A, IDX_F, 2'd1), 16'h1234, 1'b0, 16'h0000, CLEAN_MISS_CYCLES);
		add_row(1'b0, make_addr(TAG_A, IDX_F, 2'd1), 16'h0000, 1'b1, 16'h1234, HIT_CYCLES);

		// Write hits on the same line
		add_row(1'b1, make_addr(TAG_A, IDX_F, 2'd3), 16'hbeef, 1'b1, 16'h0000, HIT_CYCLES);
		add_row(1'b1, make_addr(TAG_A, IDX_F, 2'd1), 16'h5678, 1'b1, 16'h0000, HIT_CYCLES);
		add_row(1'b0, make_addr(TAG_A, IDX_F, 2'd1), 16'h0000, 1'b1, 16'h5678, HIT_CYCLES);
		add_row(1'b0, make_addr(TAG_A, IDX_F, 2'd3), 16'h0000, 1'b1, 16'hbeef, HIT_CYCLES);

		// Tag B evicts dirty tag A and then A comes back from memory
		add_row(1'b1, make_addr(TAG_B, IDX_F, 2'd2), 16'hcafe, 1'b0, 16'h0000, DIRTY_MISS_CYCLES);
		add_row(1'b0, make_addr(TAG_A, IDX_F, 2'd1), 16'h0000, 1'b0, 16'h5678, DIRTY_MISS_CYCLES);
		add_row(1'b0, make_addr(TAG_A, IDX_F, 2'd3), 16'h0000, 1'b1, 16'hbeef, HIT_CYCLES);

		// A was refilled by a read so it leaves clean
		add_row(1'b0, make_addr(TAG_B, IDX_F, 2'd2), 16'h0000, 1'b0, 16'hcafe, CLEAN_MISS_CYCLES);

		// Same pattern on a second index with word 0
		add_row(1'b1, make_addr(TAG_B, IDX_G, 2'd0), 16'h0f0f, 1'b0, 16'h0000, CLEAN_MISS_CYCLES);
		add_row(1'b1, make_addr(TAG_A, IDX_G, 2'd0), 16'ha5a5, 1'b0, 16'h0000, DIRTY_MISS_CYCLES);
		add_row(1'b0, make_addr(TAG_B, IDX_G, 2'd0), 16'h0000, 1'b0, 16'h0f0f, DIRTY_MISS_CYCLES);
		add_row(1'b0, make_addr(TAG_A, IDX_G, 2'd0), 16'h0000, 1'b0, 16'ha5a5, CLEAN_MISS_CYCLES);
		n_fixed = n_rows;
	endtask

	task automatic build_random_rows();
		addr_t a;
		word_t d;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			if (written_q.size() == 0 || ($urandom % 2) == 0)
			begin
				a = make_addr(rand_tags[$urandom % 3], rand_idx[$urandom % 4], 2'($urandom % 4));
				d = word_t'($urandom);
				add_row(1'b1, a, d, 1'b0, 16'h0000, 0);
			end
			else
			begin
				a = written_q[$urandom % written_q.size()];
				add_row(1'b0, a, 16'h0000, 1'b0, 16'h0000, 0);
			end
		end
	endtask

	// Final pass reads back every word that was ever written
	task automatic build_sweep_rows();
		foreach (written[a])
			add_row(1'b0, a, 16'h0000, 1'b0, 16'h0000, 0);
	endtask

	task automatic clear_model();
		for (int i = 0; i < NUM_LINES; i++)
		begin
			res_tag[i] = '0;
			res_valid[i] = 1'b0;
			res_dirty[i] = 1'b0;
		end
	endtask

	// Replays the whole table through the model in order
	task automatic predict_rows();
		tag_t tg;
		index_t idx;
		logic hit;
		int lat;
		for (int r = 0; r < n_rows; r++)
		begin
			tg = row_addr[r][15:11];
			idx = row_addr[r][10:3];
			hit = res_valid[idx] && (res_tag[idx] == tg);
			if (hit)
				lat = HIT_CYCLES;
			else if (res_valid[idx] && res_dirty[idx])
				lat = DIRTY_MISS_CYCLES;
			else
				lat = CLEAN_MISS_CYCLES;

			// Hand-written rows keep their own expectations
			if (r >= n_fixed)
			begin
				row_hit[r] = hit;
				row_lat[r] = lat;
				if (!row_wr[r])
					row_data[r] = model_mem[row_addr[r]];
			end

			// A miss installs the new line clean
			if (!hit)
			begin
				res_tag[idx] = tg;
				res_valid[idx] = 1'b1;
				res_dirty[idx] = 1'b0;
			end
			if (row_wr[r])
			begin
				res_dirty[idx] = 1'b1;
				model_mem[row_addr[r]] = row_wdata[r];
			end
		end
	endtask

	task automatic run_op(input int r);
		int cycles;
		int err_before;
		logic seen;
		string op_name;
		err_before = errors;
		cur_test = r + 1;
		seen = 1'b0;
		cycles = 0;
		op_name = row_wr[r] ? "write" : "read";

		@(posedge clk);
		#1;
		addr = row_addr[r];
		data_in = row_wdata[r];
		rd = !row_wr[r];
		wr = row_wr[r];

		// Acceptance cycle with the controller still idle
		@(negedge clk);
		check("stall", stall, 1'b0);
		check("done", done, 1'b0);
		check("cache_hit", cache_hit, 1'b0);

		while (!seen && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
			check("stall", stall, 1'b1);
			if (done)
			begin
				seen = 1'b1;
				check("latency", cycles, row_lat[r]);
				check("cache_hit", cache_hit, row_hit[r]);
				if (!row_wr[r])
					check("data_out", data_out, row_data[r]);
			end
			else
				check("cache_hit", cache_hit, 1'b0);
		end

		if (!seen)
		begin
			errors++;
			timed_out = 1'b1;
			$display("test %0d: no done pulse within %0d cycles of the request",
				cur_test, TIMEOUT_CYCLES);
		end

		$display("test %0d %s addr %h hit %0b cycles %0d: %s", cur_test, op_name,
			row_addr[r], row_hit[r], cycles, (errors == err_before) ? "ok" : "mismatch");
	endtask

	initial
	begin
		int err_before;
		rst = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		errors = 0;
		checks = 0;
		cur_test = 0;
		n_rows = 0;
		n_fixed = 0;
		timed_out = 1'b0;
		rand_tags = '{5'h03, 5'h11, 5'h1c};
		rand_idx = '{8'h20, 8'h21, 8'h7e, 8'hc5};

		void'($urandom(32'h75cc07e0));
		clear_model();
		build_fixed_rows();
		build_random_rows();
		build_sweep_rows();
		predict_rows();

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// Outputs right after reset
		@(negedge clk);
		err_before = errors;
		check("stall", stall, 1'b0);
		check("done", done, 1'b0);
		check("cache_hit", cache_hit, 1'b0);
		$display("test 0 reset: %s", (errors == err_before) ? "ok" : "mismatch");

		for (int r = 0; r < n_rows && !timed_out; r++)
			run_op(r);

		@(posedge clk);
		#1;
		rd = 1'b0;
		wr = 1'b0;

		// Done from the last operation must be gone
		if (!timed_out)
		begin
			@(negedge clk);
			cur_test = n_rows + 1;
			err_before = errors;
			check("stall", stall, 1'b0);
			check("done", done, 1'b0);
			$display("test %0d idle: %s", cur_test, (errors == err_before) ? "ok" : "mismatch");
		end

		$display("tests %0d, checks %0d, errors %0d", n_rows + 2, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- sim.f
hw/cache_pkg.sv
hw/cache_array_if.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/bank_memory.sv
hw/cache_ctrl.sv
hw/cache_top.sv
sim/tb_cache.sv
